/* common/cache_defines.svh */
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// data and address width
`define WORD_SIZE 16

// words per cache line, line is WORD_SIZE*LINE_WORDS bits
`define LINE_WORDS 4

// addr[15:3]
`define TAG_BITS 13

// request strobe to ack, in cycles
`define MEM_LATENCY 6

// lines in the backing RAM, covers the whole word space
`define MEM_LINES 16384

`endif

/* common/cache_pkg.sv */
`default_nettype none
`include "cache_defines.svh"

package cache_pkg;

    typedef struct packed {
        logic                  valid;
        logic                  write;
        logic [`WORD_SIZE-1:0] addr;
        logic [`WORD_SIZE-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic                  valid;
        logic                  hit;    // served without a refill
        logic [`WORD_SIZE-1:0] rdata;
    } cpu_resp_t;

    typedef struct packed {
        logic                              valid;
        logic                              write;
        logic [`WORD_SIZE-3:0]             addr;   // line address
        logic [`WORD_SIZE*`LINE_WORDS-1:0] data;
    } mem_req_t;

    typedef struct packed {
        logic                              valid;
        logic [`WORD_SIZE*`LINE_WORDS-1:0] data;
    } mem_resp_t;

    // store result for the current address
    typedef struct packed {
        logic                 hit;
        logic                 hit_way;
        logic                 victim_way;
        logic                 victim_dirty;
        logic [`TAG_BITS-1:0] victim_tag;
    } lookup_t;

    typedef enum logic [1:0] {
        OP_NONE,
        OP_TOUCH,
        OP_WRITE_WORD,
        OP_FILL
    } store_opcode_t;

    typedef struct packed {
        store_opcode_t                     opcode;
        logic                              way;
        logic                              index;
        logic [`TAG_BITS-1:0]              tag;
        logic [1:0]                        offset;
        logic [`WORD_SIZE-1:0]             word;
        logic                              dirty;  // fill after a write miss
        logic [`WORD_SIZE*`LINE_WORDS-1:0] line;
    } store_op_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITE_BACK,
        REFILL,
        FILL
    } cache_state_t;

endpackage

`default_nettype wire

/* cache/cache_store.sv */
`timescale 1ns/100ps
`default_nettype none
`include "cache_defines.svh"

module cache_store (
    input  wire logic                              clk,
    input  wire logic                              reset_n,
    input  wire logic [`WORD_SIZE-1:0]             addr,
    input  wire cache_pkg::store_op_t              op,
    output cache_pkg::lookup_t                     lookup,
    output logic [`WORD_SIZE*`LINE_WORDS-1:0]      line
);

    // arrays are indexed [way][set]
    logic [`TAG_BITS-1:0]              tag_q   [2][2];
    logic [`WORD_SIZE*`LINE_WORDS-1:0] data_q  [2][2];
    logic                              valid_q [2][2];
    logic                              dirty_q [2][2];
    logic [1:0]                        lru_q;  // per set, way to evict next

    logic                 idx;
    logic [`TAG_BITS-1:0] tag;
    logic                 hit0;
    logic                 hit1;
    logic                 victim;

    assign idx = addr[2];
    assign tag = addr[`WORD_SIZE-1 -: `TAG_BITS];

    assign hit0 = valid_q[0][idx] && (tag_q[0][idx] == tag);
    assign hit1 = valid_q[1][idx] && (tag_q[1][idx] == tag);

    always_comb begin
        // empty way first
        if (!valid_q[0][idx]) begin
            victim = 1'b0;
        end else if (!valid_q[1][idx]) begin
            victim = 1'b1;
        end else begin
            victim = lru_q[idx];
        end

        lookup.hit          = hit0 | hit1;
        lookup.hit_way      = hit1;
        lookup.victim_way   = victim;
        lookup.victim_dirty = valid_q[victim][idx] && dirty_q[victim][idx];
        lookup.victim_tag   = tag_q[victim][idx];

        line = data_q[(hit0 | hit1) ? hit1 : victim][idx];
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int w = 0; w < 2; w++) begin
                for (int s = 0; s < 2; s++) begin
                    valid_q[w][s] <= 1'b0;
                    dirty_q[w][s] <= 1'b0;
                end
            end
            lru_q <= '0;
        end else begin
            case (op.opcode)
                cache_pkg::OP_TOUCH: begin
                    lru_q[op.index] <= ~op.way;
                end
                cache_pkg::OP_WRITE_WORD: begin
                    dirty_q[op.way][op.index] <= 1'b1;
                    lru_q[op.index]           <= ~op.way;
                end
                cache_pkg::OP_FILL: begin
                    valid_q[op.way][op.index] <= 1'b1;
                    dirty_q[op.way][op.index] <= op.dirty;
                    lru_q[op.index]           <= ~op.way;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (op.opcode)
            cache_pkg::OP_WRITE_WORD: begin
                data_q[op.way][op.index][op.offset*`WORD_SIZE +: `WORD_SIZE] <= op.word;
            end
            cache_pkg::OP_FILL: begin
                tag_q[op.way][op.index]  <= op.tag;
                data_q[op.way][op.index] <= op.line;  // already merged by ctrl
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* cache/cache_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none
`include "cache_defines.svh"

module cache_ctrl (
    input  wire logic                              clk,
    input  wire logic                              reset_n,
    input  wire cache_pkg::cpu_req_t               cpu_req,
    input  wire cache_pkg::lookup_t                lookup,
    input  wire logic [`WORD_SIZE*`LINE_WORDS-1:0] line,
    input  wire cache_pkg::mem_resp_t              mem_resp,
    output cache_pkg::cpu_resp_t                   cpu_resp,
    output logic [`WORD_SIZE-1:0]                  addr,
    output cache_pkg::store_op_t                   op,
    output cache_pkg::mem_req_t                    mem_req
);

    cache_pkg::cache_state_t state;

    logic                              req_write;
    logic [`WORD_SIZE-1:0]             req_wdata;
    logic                              fill_way;
    logic [`WORD_SIZE*`LINE_WORDS-1:0] fill_line;
    logic [`WORD_SIZE*`LINE_WORDS-1:0] merged_line;
    logic                              refill_sent;  // read strobe already out

    logic                 idx;
    logic [1:0]           offset;
    logic [`TAG_BITS-1:0] tag;

    assign idx    = addr[2];
    assign offset = addr[1:0];
    assign tag    = addr[`WORD_SIZE-1 -: `TAG_BITS];

    // write miss puts the CPU word into the fetched line
    always_comb begin
        merged_line = fill_line;
        if (req_write) begin
            merged_line[offset*`WORD_SIZE +: `WORD_SIZE] = req_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state       <= cache_pkg::IDLE;
            cpu_resp    <= '0;
            mem_req     <= '0;
            op          <= '0;
            refill_sent <= 1'b0;
        end else begin
            cpu_resp.valid <= 1'b0;
            mem_req.valid  <= 1'b0;
            op.opcode      <= cache_pkg::OP_NONE;

            case (state)
                cache_pkg::IDLE: begin
                    if (cpu_req.valid) begin
                        state <= cache_pkg::LOOKUP;
                    end
                end
                cache_pkg::LOOKUP: begin
                    if (lookup.hit) begin
                        cpu_resp <= '{valid: 1'b1, hit: 1'b1,
                                      rdata: line[offset*`WORD_SIZE +: `WORD_SIZE]};
                        op <= '{opcode: req_write ? cache_pkg::OP_WRITE_WORD
                                                  : cache_pkg::OP_TOUCH,
                                way: lookup.hit_way, index: idx, tag: tag,
                                offset: offset, word: req_wdata, dirty: 1'b0,
                                line: line};
                        state <= cache_pkg::IDLE;
                    end else if (lookup.victim_dirty) begin
                        // old line goes back to its own address
                        mem_req <= '{valid: 1'b1, write: 1'b1,
                                     addr: {lookup.victim_tag, idx}, data: line};
                        state <= cache_pkg::WRITE_BACK;
                    end else begin
                        state <= cache_pkg::REFILL;
                    end
                end
                cache_pkg::WRITE_BACK: begin
                    if (mem_resp.valid) begin
                        state <= cache_pkg::REFILL;
                    end
                end
                cache_pkg::REFILL: begin
                    if (!refill_sent) begin
                        mem_req <= '{valid: 1'b1, write: 1'b0,
                                     addr: addr[`WORD_SIZE-1:2], data: '0};
                        refill_sent <= 1'b1;
                    end else if (mem_resp.valid) begin
                        refill_sent <= 1'b0;
                        state       <= cache_pkg::FILL;
                    end
                end
                cache_pkg::FILL: begin
                    cpu_resp <= '{valid: 1'b1, hit: 1'b0,
                                  rdata: fill_line[offset*`WORD_SIZE +: `WORD_SIZE]};
                    op <= '{opcode: cache_pkg::OP_FILL, way: fill_way, index: idx,
                            tag: tag, offset: offset, word: req_wdata,
                            dirty: req_write, line: merged_line};
                    state <= cache_pkg::IDLE;
                end
                default: state <= cache_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == cache_pkg::IDLE && cpu_req.valid) begin
            addr      <= cpu_req.addr;
            req_write <= cpu_req.write;
            req_wdata <= cpu_req.wdata;
        end
        if (state == cache_pkg::LOOKUP) begin
            fill_way <= lookup.victim_way;  // store is untouched until FILL
        end
        if (state == cache_pkg::REFILL && refill_sent && mem_resp.valid) begin
            fill_line <= mem_resp.data;
        end
    end

endmodule

`default_nettype wire

/* hdl/line_memory.sv */
`timescale 1ns/100ps
`default_nettype none
`include "cache_defines.svh"

module line_memory (
    input  wire logic                 clk,
    input  wire logic                 reset_n,
    input  wire cache_pkg::mem_req_t  req,
    output cache_pkg::mem_resp_t      resp
);

    localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

    logic [`WORD_SIZE*`LINE_WORDS-1:0] ram [`MEM_LINES];

    logic                              busy;
    logic [CNT_W-1:0]                  cnt;
    logic                              resp_valid;
    logic [`WORD_SIZE*`LINE_WORDS-1:0] resp_data;
    logic                              op_write;
    logic [`WORD_SIZE-3:0]             op_addr;
    logic [`WORD_SIZE*`LINE_WORDS-1:0] op_data;

    // word at address a holds a ^ 16'h5a5a
    initial begin
        for (int l = 0; l < `MEM_LINES; l++) begin
            for (int o = 0; o < `LINE_WORDS; o++) begin
                ram[l][o*`WORD_SIZE +: `WORD_SIZE] = `WORD_SIZE'(l*`LINE_WORDS + o) ^ 16'h5a5a;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            busy       <= 1'b0;
            cnt        <= '0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            if (busy) begin
                if (cnt == CNT_W'(1)) begin
                    busy       <= 1'b0;
                    resp_valid <= 1'b1;
                end else begin
                    cnt <= cnt - 1'b1;
                end
            end else if (req.valid) begin
                busy <= 1'b1;
                cnt  <= CNT_W'(`MEM_LATENCY - 1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && req.valid) begin
            op_write <= req.write;
            op_addr  <= req.addr;
            op_data  <= req.data;
        end
        if (busy && cnt == CNT_W'(1)) begin
            if (op_write) begin
                ram[op_addr] <= op_data;
            end else begin
                resp_data <= ram[op_addr];
            end
        end
    end

    assign resp = '{valid: resp_valid, data: resp_data};

endmodule

`default_nettype wire

/* hdl/mem_system.sv */
`timescale 1ns/100ps
`default_nettype none
`include "cache_defines.svh"

module mem_system (
    input  wire logic                clk,
    input  wire logic                reset_n,
    input  wire cache_pkg::cpu_req_t cpu_req,
    output cache_pkg::cpu_resp_t     cpu_resp
);

    cache_pkg::lookup_t                lookup;
    cache_pkg::store_op_t              op;
    cache_pkg::mem_req_t               mem_req;
    cache_pkg::mem_resp_t              mem_resp;
    logic [`WORD_SIZE-1:0]             addr;     // registered request address
    logic [`WORD_SIZE*`LINE_WORDS-1:0] line;     // hit or victim line

    cache_ctrl u_ctrl (
        .clk      (clk),
        .reset_n  (reset_n),
        .cpu_req  (cpu_req),
        .lookup   (lookup),
        .line     (line),
        .mem_resp (mem_resp),
        .cpu_resp (cpu_resp),
        .addr     (addr),
        .op       (op),
        .mem_req  (mem_req)
    );

    cache_store u_store (
        .clk     (clk),
        .reset_n (reset_n),
        .addr    (addr),
        .op      (op),
        .lookup  (lookup),
        .line    (line)
    );

    line_memory u_mem (
        .clk     (clk),
        .reset_n (reset_n),
        .req     (mem_req),
        .resp    (mem_resp)
    );

endmodule

`default_nettype wire

/* verif/tb_mem_system.sv */
`timescale 1ns/100ps
`default_nettype none
`include "cache_defines.svh"

module tb_mem_system;

    localparam int DIRECTED_OPS   = 13;
    localparam int RANDOM_OPS     = 200;
    localparam int TIMEOUT_CYCLES = (DIRECTED_OPS + RANDOM_OPS) * (2*`MEM_LATENCY + 6) + 500;

    logic                 clk;
    logic                 reset_n;
    cache_pkg::cpu_req_t  cpu_req;
    cache_pkg::cpu_resp_t cpu_resp;

    // architectural memory and a tag model of the cache
    logic [15:0]          shadow_mem  [65536];
    logic [`TAG_BITS-1:0] model_tag   [2][2];  // [way][set]
    logic                 model_valid [2][2];
    logic [1:0]           model_lru;           // per set, way to evict next

    logic        pending;      // request out, response not yet checked
    logic        exp_hit;
    logic        exp_is_read;
    logic [15:0] exp_rdata;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          test_errors_base = 0;
    integer      seed;

    mem_system UUT (
        .clk      (clk),
        .reset_n  (reset_n),
        .cpu_req  (cpu_req),
        .cpu_resp (cpu_resp)
    );

    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // expected {hit, rdata} for one access, updates the model as the cache would
    function automatic logic [16:0] predict_access(input logic write, input logic [15:0] addr,
                                                   input logic [15:0] wdata);
        logic                 set;
        logic [`TAG_BITS-1:0] tag;
        logic                 way;
        logic                 hit;
        logic [15:0]          rdata;
        set = addr[2];
        tag = addr[15:3];
        hit = 1'b0;
        way = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (model_valid[w][set] && model_tag[w][set] == tag) begin
                hit = 1'b1;
                way = w[0];
            end
        end
        if (!hit) begin
            if (!model_valid[0][set]) begin
                way = 1'b0;
            end else if (!model_valid[1][set]) begin
                way = 1'b1;
            end else begin
                way = model_lru[set];
            end
            model_valid[way][set] = 1'b1;
            model_tag[way][set]   = tag;
        end
        model_lru[set] = ~way;
        rdata = shadow_mem[addr];
        if (write) begin
            shadow_mem[addr] = wdata;
        end
        return {hit, rdata};
    endfunction

    // called on a rising edge, returns on the edge that sees the response
    task automatic access(input logic write, input logic [15:0] addr, input logic [15:0] wdata,
                          output logic hit, output logic [15:0] rdata, output int edges);
        logic [16:0] expected;
        expected    = predict_access(write, addr, wdata);
        exp_hit     = expected[16];
        exp_rdata   = expected[15:0];
        exp_is_read = !write;
        pending     = 1'b1;
        cpu_req <= '{valid: 1'b1, write: write, addr: addr, wdata: wdata};
        @(posedge clk);
        cpu_req.valid <= 1'b0;
        edges = 0;  // edges after the DUT samples the request
        while (!cpu_resp.valid) begin
            @(posedge clk);
            edges++;
        end
        hit   = cpu_resp.hit;
        rdata = cpu_resp.rdata;
    endtask

    task automatic report_test(input string name);
        wait (!pending);
        @(posedge clk);
        $display("test %-12s %0d mismatches", name, errors - test_errors_base);
        test_errors_base = errors;
    endtask

    // compares every response against the reference
    always @(negedge clk) begin
        if (reset_n && cpu_resp.valid) begin
            if (!pending) begin
                $display("the DUT answered while no request was outstanding");
                errors++;
            end else begin
                check_value("cpu_resp.hit", exp_hit, cpu_resp.hit);
                if (exp_is_read) begin
                    check_value("cpu_resp.rdata", exp_rdata, cpu_resp.rdata);
                end
                pending = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the DUT stopped answering", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        logic        hit;
        logic [15:0] rdata;
        int          edges;
        logic [15:0] r_addr;
        logic        r_write;
        logic [15:0] r_wdata;
        clk     = 1'b0;
        reset_n = 1'b0;
        cpu_req = '0;
        pending = 1'b0;
        seed    = 98;
        for (int a = 0; a < 65536; a++) begin
            shadow_mem[a] = 16'(a) ^ 16'h5a5a;
        end
        for (int w = 0; w < 2; w++) begin
            model_valid[w][0] = 1'b0;
            model_valid[w][1] = 1'b0;
        end
        model_lru = '0;

        repeat (4) @(posedge clk);
        reset_n <= 1'b1;
        repeat (5) begin
            @(posedge clk);
            check_value("cpu_resp.valid", 16'h0, {15'h0, cpu_resp.valid});
        end
        access(1'b0, 16'h0040, 16'h0, hit, rdata, edges);
        check_value("cpu_resp.hit", 16'h0, {15'h0, hit});
        report_test("after_reset");

        access(1'b0, 16'h0042, 16'h0, hit, rdata, edges);
        check_value("cpu_resp.hit", 16'h1, {15'h0, hit});
        check_value("hit_latency", 16'd2, 16'(edges));
        report_test("read_hit");

        access(1'b1, 16'h0041, 16'hbeef, hit, rdata, edges);
        check_value("cpu_resp.hit", 16'h1, {15'h0, hit});
        access(1'b0, 16'h0041, 16'h0, hit, rdata, edges);
        check_value("cpu_resp.rdata", 16'hbeef, rdata);
        report_test("write_hit");

        // three tags in set 1, A touched again before C comes in
        access(1'b0, 16'h1004, 16'h0, hit, rdata, edges);
        access(1'b0, 16'h2004, 16'h0, hit, rdata, edges);
        access(1'b0, 16'h1004, 16'h0, hit, rdata, edges);
        access(1'b0, 16'h3004, 16'h0, hit, rdata, edges);
        access(1'b0, 16'h1004, 16'h0, hit, rdata, edges);
        check_value("cpu_resp.hit", 16'h1, {15'h0, hit});
        access(1'b0, 16'h2004, 16'h0, hit, rdata, edges);
        check_value("cpu_resp.hit", 16'h0, {15'h0, hit});
        report_test("lru_evict");

        // pushes the dirty 0x0040 line out of set 0
        access(1'b0, 16'h1040, 16'h0, hit, rdata, edges);
        access(1'b0, 16'h2040, 16'h0, hit, rdata, edges);
        access(1'b0, 16'h0041, 16'h0, hit, rdata, edges);
        check_value("cpu_resp.hit", 16'h0, {15'h0, hit});
        check_value("cpu_resp.rdata", 16'hbeef, rdata);
        report_test("write_back");

        repeat (RANDOM_OPS) begin
            r_addr  = 16'($random(seed)) & 16'hc007;  // 4 tags, both sets
            r_write = 1'($random(seed));
            r_wdata = 16'($random(seed));
            access(r_write, r_addr, r_wdata, hit, rdata, edges);
        end
        report_test("random_mix");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+common
common/cache_pkg.sv
cache/cache_store.sv
cache/cache_ctrl.sv
hdl/line_memory.sv
hdl/mem_system.sv
verif/tb_mem_system.sv

/* Makefile */
# Verilator build and run for the cache memory subsystem

TOP = tb_mem_system
LOG = sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing -Wno-fatal -f build.f --top-module $(TOP) -Mdir obj_dir -o sim
	./obj_dir/sim | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "simulation did not pass"; exit 1)

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
